// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_execute
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard design/*.sv sim/*.sv sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+sim
design/isa_pkg.sv
design/exec_pkg.sv
design/alu.sv
design/branch_unit.sv
design/mem_access.sv
design/csr_access.sv
design/trap_unit.sv
design/writeback_stage.sv
design/execute_stage.sv
sim/tb_execute.sv

// File: design/alu.sv
// ALU with adder, logic, shifts and signed/unsigned comparisons
`timescale 1ns/1ps
`default_nettype none

module alu import isa_pkg::*, exec_pkg::*; (
    input  op_e             op_i,
    input  logic [XLEN-1:0] operand_a_i,    // rs1 data
    input  logic [XLEN-1:0] operand_b_i,    // Second operand
    output logic [XLEN-1:0] sum_o,
    output logic [XLEN-1:0] and_o,
    output logic [XLEN-1:0] or_o,
    output logic [XLEN-1:0] xor_o,
    output logic [XLEN-1:0] sll_o,
    output logic [XLEN-1:0] srl_o,
    output logic [XLEN-1:0] sra_o,
    output cmp_t            cmp_o
);

    logic [XLEN-1:0] addend_b;
    logic [4:0]      shamt;

    assign addend_b = (op_i == SUB) ? -operand_b_i : operand_b_i;
    assign shamt    = operand_b_i[4:0];

    assign sum_o = operand_a_i + addend_b;   // Also address and JALR target
    assign and_o = operand_a_i & operand_b_i;
    assign or_o  = operand_a_i | operand_b_i;
    assign xor_o = operand_a_i ^ operand_b_i;
    assign sll_o = operand_a_i << shamt;
    assign srl_o = operand_a_i >> shamt;
    assign sra_o = $signed(operand_a_i) >>> shamt;

    // Flags for branches and SLT/SLTU
    assign cmp_o.equal           = (operand_a_i == operand_b_i);
    assign cmp_o.less_than       = $signed(operand_a_i) <  $signed(operand_b_i);
    assign cmp_o.less_than_u     = operand_a_i <  operand_b_i;
    assign cmp_o.greater_equal   = $signed(operand_a_i) >= $signed(operand_b_i);
    assign cmp_o.greater_equal_u = operand_a_i >= operand_b_i;

endmodule

`default_nettype wire

// File: design/branch_unit.sv
// Branch decision, jump target and target misalignment check
`timescale 1ns/1ps
`default_nettype none

module branch_unit import isa_pkg::*, exec_pkg::*; #(
    parameter bit COMPRESSED = 1'b1
) (
    input  op_e             op_i,
    input  cmp_t            cmp_i,
    input  logic [XLEN-1:0] sum_i,
    input  logic [XLEN-1:0] jump_imm_target_i,
    output logic            jump_o,
    output logic [XLEN-1:0] jump_target_o,
    output logic            target_misaligned_o
);

    always_comb begin
        unique case (op_i)
            BEQ:       jump_o = cmp_i.equal;
            BNE:       jump_o = !cmp_i.equal;
            BLT:       jump_o = cmp_i.less_than;
            BLTU:      jump_o = cmp_i.less_than_u;
            BGE:       jump_o = cmp_i.greater_equal;
            BGEU:      jump_o = cmp_i.greater_equal_u;
            JAL, JALR: jump_o = 1'b1;
            default:   jump_o = 1'b0;
        endcase
    end

    // JALR target is rs1 plus offset with bit 0 dropped
    assign jump_target_o = (op_i == JALR) ? {sum_i[XLEN-1:1], 1'b0} : jump_imm_target_i;

    // Without compressed support every target must be word aligned
    assign target_misaligned_o = !COMPRESSED && jump_o && jump_target_o[1];

endmodule

`default_nettype wire

// File: design/csr_access.sv
// CSR read/write enables, operation, write data and illegal access check
`timescale 1ns/1ps
`default_nettype none

module csr_access import isa_pkg::*, exec_pkg::*; (
    input  op_e                   op_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [CSR_ADDR_W-1:0] csr_address_i,
    input  priv_e                 privilege_i,
    output csr_req_t              csr_req_o,
    output logic                  csr_illegal_o
);

    logic read_enable;
    logic write_enable;

    always_comb begin
        read_enable  = 1'b0;
        write_enable = 1'b0;
        csr_req_o.operation = CSR_NONE;
        unique case (op_i)
            CSRRW, CSRRWI: begin
                read_enable  = (rd_i != '0);   // No read side effect when rd is x0
                write_enable = 1'b1;
                csr_req_o.operation = CSR_WRITE;
            end
            CSRRS, CSRRSI: begin
                read_enable  = 1'b1;
                write_enable = (rs1_i != '0);
                csr_req_o.operation = CSR_SET;
            end
            CSRRC, CSRRCI: begin
                read_enable  = 1'b1;
                write_enable = (rs1_i != '0);
                csr_req_o.operation = CSR_CLEAR;
            end
            default: ;
        endcase
    end

    // Bits 11:10 == 11 mark read-only CSRs and bits 9:8 the lowest privilege allowed
    assign csr_illegal_o = ((csr_address_i[11:10] == 2'b11) && write_enable)
                         || ((csr_address_i[9:8] > 2'(privilege_i))
                             && (read_enable || write_enable));

    assign csr_req_o.read_enable  = read_enable && !csr_illegal_o;
    assign csr_req_o.write_enable = write_enable && !csr_illegal_o;
    assign csr_req_o.address      = csr_address_i;
    assign csr_req_o.data = (op_i inside {CSRRWI, CSRRSI, CSRRCI})
                          ? {{(XLEN-REG_ADDR_W){1'b0}}, rs1_i} : rs1_data_i;

    always_comb begin
        a_no_enable_when_illegal: assert final (!(csr_illegal_o
            && (csr_req_o.read_enable || csr_req_o.write_enable)))
            else $error("CSR enable set on an illegal access");
    end

endmodule

`default_nettype wire

// File: design/exec_pkg.sv
// Stage input, comparison flags, memory request, CSR request
// and writeback payload structs
`default_nettype none

package exec_pkg;
    import isa_pkg::*;

    typedef struct packed {
        op_e                   op;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       second_operand;    // rs2 or immediate
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [XLEN-1:0]       jump_imm_target;   // PC plus immediate
        logic [XLEN-1:0]       pc_next;
        logic [CSR_ADDR_W-1:0] csr_address;
        priv_e                 privilege;
        logic                  illegal_inst;
    } exec_in_t;

    typedef struct packed {
        logic equal;
        logic less_than;
        logic less_than_u;
        logic greater_equal;
        logic greater_equal_u;
    } cmp_t;

    typedef struct packed {
        logic [XLEN-1:0]  address;
        logic             read_enable;
        logic [BYTES-1:0] byte_enable;
        logic [XLEN-1:0]  write_data;
    } mem_req_t;

    typedef struct packed {
        logic                  read_enable;
        logic                  write_enable;
        csr_op_e               operation;
        logic [CSR_ADDR_W-1:0] address;
        logic [XLEN-1:0]       data;
    } csr_req_t;

    typedef struct packed {
        logic                  write_enable;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        op_e                   op;
    } wb_t;

endpackage

`default_nettype wire

// File: design/execute_stage.sv
// Execute stage top level connecting ALU, branch, memory, CSR,
// trap and writeback units
`timescale 1ns/1ps
`default_nettype none

module execute_stage import isa_pkg::*, exec_pkg::*; #(
    parameter bit COMPRESSED = 1'b1    // Allow halfword aligned jump targets
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            stall_i,
    input  exec_in_t        exec_in_i,
    input  logic [XLEN-1:0] csr_data_read_i,
    output mem_req_t        mem_req_o,
    output wb_t             wb_o,
    output csr_req_t        csr_req_o,
    output logic            jump_o,
    output logic [XLEN-1:0] jump_target_o,
    output logic            raise_exception_o,
    output exc_code_e       exception_code_o
);

    logic [XLEN-1:0] sum_result;
    logic [XLEN-1:0] and_result;
    logic [XLEN-1:0] or_result;
    logic [XLEN-1:0] xor_result;
    logic [XLEN-1:0] sll_result;
    logic [XLEN-1:0] srl_result;
    logic [XLEN-1:0] sra_result;
    cmp_t            cmp;

    logic target_misaligned;
    logic load_misaligned;
    logic store_misaligned;
    logic csr_illegal;

    ////////////////////////////////////////////////////////////////////////
    // Datapath units
    ////////////////////////////////////////////////////////////////////////

    alu u_alu (
        .op_i        (exec_in_i.op),
        .operand_a_i (exec_in_i.rs1_data),
        .operand_b_i (exec_in_i.second_operand),
        .sum_o       (sum_result),
        .and_o       (and_result),
        .or_o        (or_result),
        .xor_o       (xor_result),
        .sll_o       (sll_result),
        .srl_o       (srl_result),
        .sra_o       (sra_result),
        .cmp_o       (cmp)
    );

    branch_unit #(
        .COMPRESSED (COMPRESSED)
    ) u_branch_unit (
        .op_i                (exec_in_i.op),
        .cmp_i               (cmp),
        .sum_i               (sum_result),
        .jump_imm_target_i   (exec_in_i.jump_imm_target),
        .jump_o              (jump_o),
        .jump_target_o       (jump_target_o),
        .target_misaligned_o (target_misaligned)
    );

    mem_access u_mem_access (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall_i            (stall_i),
        .op_i               (exec_in_i.op),
        .sum_i              (sum_result),
        .rs2_data_i         (exec_in_i.rs2_data),
        .mem_req_o          (mem_req_o),
        .load_misaligned_o  (load_misaligned),
        .store_misaligned_o (store_misaligned)
    );

    ////////////////////////////////////////////////////////////////////////
    // Control and writeback
    ////////////////////////////////////////////////////////////////////////

    csr_access u_csr_access (
        .op_i          (exec_in_i.op),
        .rd_i          (exec_in_i.rd),
        .rs1_i         (exec_in_i.rs1),
        .rs1_data_i    (exec_in_i.rs1_data),
        .csr_address_i (exec_in_i.csr_address),
        .privilege_i   (exec_in_i.privilege),
        .csr_req_o     (csr_req_o),
        .csr_illegal_o (csr_illegal)
    );

    trap_unit u_trap_unit (
        .op_i                (exec_in_i.op),
        .privilege_i         (exec_in_i.privilege),
        .illegal_inst_i      (exec_in_i.illegal_inst),
        .csr_illegal_i       (csr_illegal),
        .target_misaligned_i (target_misaligned),
        .load_misaligned_i   (load_misaligned),
        .store_misaligned_i  (store_misaligned),
        .raise_exception_o   (raise_exception_o),
        .exception_code_o    (exception_code_o)
    );

    writeback_stage u_writeback_stage (
        .clk               (clk),
        .reset_n           (reset_n),
        .stall_i           (stall_i),
        .exec_in_i         (exec_in_i),
        .sum_i             (sum_result),
        .and_i             (and_result),
        .or_i              (or_result),
        .xor_i             (xor_result),
        .sll_i             (sll_result),
        .srl_i             (srl_result),
        .sra_i             (sra_result),
        .cmp_i             (cmp),
        .csr_data_read_i   (csr_data_read_i),
        .raise_exception_i (raise_exception_o),   // Blocks the register write
        .wb_o              (wb_o)
    );

endmodule

`default_nettype wire

// File: design/isa_pkg.sv
// RV32I operation, CSR operation, privilege and exception cause encodings
// Data, register index, CSR address and byte lane widths
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int BYTES      = 4;    // Byte lanes per word

    // Operation decoded upstream
    typedef enum logic [5:0] {
        NOP,
        ADD, SUB, SLT, SLTU,
        XOR, OR, AND,
        SLL, SRL, SRA,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        CSRRW, CSRRS, CSRRC,
        CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK
    } op_e;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_e;

    typedef enum logic [1:0] {
        USER       = 2'b00,
        SUPERVISOR = 2'b01,
        MACHINE    = 2'b11
    } priv_e;

    // Values follow the mcause numbering
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR         = 4'd2,
        BREAKPOINT            = 4'd3,
        LOAD_ADDR_MISALIGNED  = 4'd4,
        STORE_ADDR_MISALIGNED = 4'd6,
        ECALL_UMODE           = 4'd8,
        ECALL_MMODE           = 4'd11,
        NO_EXC                = 4'd15
    } exc_code_e;

endpackage

`default_nettype wire

// File: design/mem_access.sv
// Load/store address, byte lanes, write data and misalignment flags
// Registered memory request for the next stage
`timescale 1ns/1ps
`default_nettype none

module mem_access import isa_pkg::*, exec_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            stall_i,
    input  op_e             op_i,
    input  logic [XLEN-1:0] sum_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output mem_req_t        mem_req_o,
    output logic            load_misaligned_o,
    output logic            store_misaligned_o
);

    mem_req_t req;

    assign req.address     = sum_i;
    assign req.read_enable = op_i inside {LB, LBU, LH, LHU, LW};

    always_comb begin
        req.byte_enable = '0;
        unique case (op_i)
            SB:      req.byte_enable[sum_i[1:0]] = 1'b1;
            SH:      req.byte_enable = sum_i[1] ? 4'b1100 : 4'b0011;
            SW:      req.byte_enable = '1;
            default: req.byte_enable = '0;
        endcase
    end

    always_comb begin
        unique case (op_i)
            SB:      req.write_data = {BYTES{rs2_data_i[7:0]}};   // Byte on every lane
            SH:      req.write_data = {2{rs2_data_i[15:0]}};
            default: req.write_data = rs2_data_i;
        endcase
    end

    assign load_misaligned_o = ((op_i inside {LH, LHU}) && sum_i[0])
                             || ((op_i == LW) && (sum_i[1:0] != 2'b00));
    assign store_misaligned_o = ((op_i == SH) && sum_i[0])
                              || ((op_i == SW) && (sum_i[1:0] != 2'b00));

    //////////////////////////////////////////////////////////////////////
    // Request register held under stall
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_req_o <= '0;
        end else if (!stall_i) begin
            mem_req_o <= req;
        end
    end

    a_byte_enable_legal: assert property (@(posedge clk) disable iff (!reset_n)
        mem_req_o.byte_enable inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                                      4'b1000, 4'b0011, 4'b1100, 4'b1111})
        else $error("Illegal byte lane pattern %b", mem_req_o.byte_enable);

endmodule

`default_nettype wire

// File: design/trap_unit.sv
// Exception raise and prioritized exception code
`timescale 1ns/1ps
`default_nettype none

module trap_unit import isa_pkg::*; (
    input  op_e       op_i,
    input  priv_e     privilege_i,
    input  logic      illegal_inst_i,
    input  logic      csr_illegal_i,
    input  logic      target_misaligned_i,
    input  logic      load_misaligned_i,
    input  logic      store_misaligned_i,
    output logic      raise_exception_o,
    output exc_code_e exception_code_o
);

    logic any_cause;

    assign any_cause = illegal_inst_i || csr_illegal_i || target_misaligned_i
                     || load_misaligned_i || store_misaligned_i
                     || (op_i inside {ECALL, EBREAK});

    assign raise_exception_o = any_cause && (op_i != NOP);   // Bubbles never trap

    // Highest priority first
    always_comb begin
        if (illegal_inst_i || csr_illegal_i)
            exception_code_o = ILLEGAL_INSTR;
        else if (target_misaligned_i)
            exception_code_o = INSTR_ADDR_MISALIGNED;
        else if (op_i == ECALL)
            exception_code_o = (privilege_i == USER) ? ECALL_UMODE : ECALL_MMODE;
        else if (op_i == EBREAK)
            exception_code_o = BREAKPOINT;
        else if (load_misaligned_i)
            exception_code_o = LOAD_ADDR_MISALIGNED;
        else if (store_misaligned_i)
            exception_code_o = STORE_ADDR_MISALIGNED;
        else
            exception_code_o = NO_EXC;
    end

    always_comb begin
        a_raise_matches_code: assert final (raise_exception_o
            == ((exception_code_o != NO_EXC) && (op_i != NOP)))
            else $error("Raise and exception code disagree");
    end

endmodule

`default_nettype wire

// File: design/writeback_stage.sv
// Result selection, register write enable and registered writeback payload
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import isa_pkg::*, exec_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            stall_i,
    input  exec_in_t        exec_in_i,
    input  logic [XLEN-1:0] sum_i,
    input  logic [XLEN-1:0] and_i,
    input  logic [XLEN-1:0] or_i,
    input  logic [XLEN-1:0] xor_i,
    input  logic [XLEN-1:0] sll_i,
    input  logic [XLEN-1:0] srl_i,
    input  logic [XLEN-1:0] sra_i,
    input  cmp_t            cmp_i,
    input  logic [XLEN-1:0] csr_data_read_i,
    input  logic            raise_exception_i,
    output wb_t             wb_o
);

    wb_t wb;

    always_comb begin
        unique case (exec_in_i.op)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI: wb.result = csr_data_read_i;
            JAL, JALR:              wb.result = exec_in_i.pc_next;    // Link address
            SLT:                    wb.result = {{(XLEN-1){1'b0}}, cmp_i.less_than};
            SLTU:                   wb.result = {{(XLEN-1){1'b0}}, cmp_i.less_than_u};
            XOR:                    wb.result = xor_i;
            OR:                     wb.result = or_i;
            AND:                    wb.result = and_i;
            SLL:                    wb.result = sll_i;
            SRL:                    wb.result = srl_i;
            SRA:                    wb.result = sra_i;
            LUI:                    wb.result = exec_in_i.second_operand;
            AUIPC:                  wb.result = exec_in_i.jump_imm_target;
            default:                wb.result = sum_i;    // ADD, SUB, loads
        endcase
    end

    // Stores and branches have no destination register
    assign wb.write_enable = !(exec_in_i.op inside {NOP, SB, SH, SW,
                                                    BEQ, BNE, BLT, BLTU, BGE, BGEU})
                           && (exec_in_i.rd != '0) && !raise_exception_i;
    assign wb.rd = exec_in_i.rd;
    assign wb.op = exec_in_i.op;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_o <= '{write_enable: 1'b0, rd: '0, result: '0, op: NOP};
        end else if (!stall_i) begin
            wb_o <= wb;
        end
    end

endmodule

`default_nettype wire

// File: sim/exec_model.svh
// Reference model for the execute stage outputs
// Results, branch outcome, memory and CSR requests, trap cause
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Adder result with B negated only for SUB
function automatic logic [XLEN-1:0] operand_sum(input exec_in_t instr);
    if (instr.op == SUB)
        return instr.rs1_data - instr.second_operand;
    return instr.rs1_data + instr.second_operand;
endfunction

function automatic logic [XLEN-1:0] select_result(input exec_in_t instr,
                                                  input logic [XLEN-1:0] csr_rd);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = instr.rs1_data;
    b = instr.second_operand;
    case (instr.op)
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI: return csr_rd;
        JAL, JALR: return instr.pc_next;
        SLT:       return XLEN'($signed(a) < $signed(b));
        SLTU:      return XLEN'(a < b);
        XOR:       return a ^ b;
        OR:        return a | b;
        AND:       return a & b;
        SLL:       return a << b[4:0];
        SRL:       return a >> b[4:0];
        SRA:       return $unsigned($signed(a) >>> b[4:0]);
        LUI:       return b;
        AUIPC:     return instr.jump_imm_target;
        default:   return operand_sum(instr);
    endcase
endfunction

function automatic logic write_allowed(input exec_in_t instr, input logic raise);
    if (instr.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU})
        return 1'b0;
    return (instr.rd != 0) && !raise;
endfunction

function automatic void branch_outcome(input exec_in_t instr, output logic taken,
                                       output logic [XLEN-1:0] target);
    logic signed [XLEN-1:0] a;
    logic signed [XLEN-1:0] b;
    a = instr.rs1_data;
    b = instr.second_operand;
    case (instr.op)
        BEQ:       taken = (a == b);
        BNE:       taken = (a != b);
        BLT:       taken = (a < b);
        BGE:       taken = (a >= b);
        BLTU:      taken = ($unsigned(a) < $unsigned(b));
        BGEU:      taken = ($unsigned(a) >= $unsigned(b));
        JAL, JALR: taken = 1'b1;
        default:   taken = 1'b0;
    endcase
    target = (instr.op == JALR) ? (operand_sum(instr) & ~XLEN'(1)) : instr.jump_imm_target;
endfunction

function automatic mem_req_t memory_request(input exec_in_t instr);
    mem_req_t req;
    req.address     = operand_sum(instr);
    req.read_enable = instr.op inside {LB, LBU, LH, LHU, LW};
    req.byte_enable = 4'b0000;
    req.write_data  = instr.rs2_data;
    if (instr.op == SB) begin
        req.byte_enable = 4'b0001 << req.address[1:0];
        req.write_data  = {4{instr.rs2_data[7:0]}};
    end else if (instr.op == SH) begin
        req.byte_enable = req.address[1] ? 4'b1100 : 4'b0011;
        req.write_data  = {2{instr.rs2_data[15:0]}};
    end else if (instr.op == SW) begin
        req.byte_enable = 4'b1111;
    end
    return req;
endfunction

// Load flag in bit 1 and store flag in bit 0
function automatic logic [1:0] misaligned_access(input exec_in_t instr);
    logic [XLEN-1:0] addr;
    addr = operand_sum(instr);
    return {(instr.op inside {LH, LHU} && addr[0]) || (instr.op == LW && addr[1:0] != 2'b00),
            (instr.op == SH && addr[0]) || (instr.op == SW && addr[1:0] != 2'b00)};
endfunction

function automatic csr_req_t csr_request(input exec_in_t instr, output logic illegal);
    csr_req_t req;
    logic     immediate;
    immediate   = instr.op inside {CSRRWI, CSRRSI, CSRRCI};
    req         = '0;
    req.address = instr.csr_address;
    req.data    = immediate ? XLEN'(instr.rs1) : instr.rs1_data;
    if (instr.op inside {CSRRW, CSRRWI}) begin
        req.operation    = CSR_WRITE;
        req.read_enable  = (instr.rd != 0);
        req.write_enable = 1'b1;
    end else if (instr.op inside {CSRRS, CSRRSI, CSRRC, CSRRCI}) begin
        req.operation    = (instr.op inside {CSRRS, CSRRSI}) ? CSR_SET : CSR_CLEAR;
        req.read_enable  = 1'b1;
        req.write_enable = (instr.rs1 != 0);
    end
    illegal = (req.write_enable && instr.csr_address[11:10] == 2'b11)
           || ((req.read_enable || req.write_enable)
               && instr.csr_address[9:8] > 2'(instr.privilege));
    if (illegal) begin
        req.read_enable  = 1'b0;
        req.write_enable = 1'b0;
    end
    return req;
endfunction

function automatic void trap_outcome(input exec_in_t instr, output logic raise,
                                     output exc_code_e code);
    logic            taken;
    logic [XLEN-1:0] target;
    logic            csr_bad;
    logic [1:0]      mis;
    branch_outcome(instr, taken, target);
    void'(csr_request(instr, csr_bad));
    mis = misaligned_access(instr);
    // Highest priority cause first
    if (instr.illegal_inst || csr_bad)
        code = ILLEGAL_INSTR;
    else if (!COMPRESSED && taken && target[1])
        code = INSTR_ADDR_MISALIGNED;
    else if (instr.op == ECALL)
        code = (instr.privilege == USER) ? ECALL_UMODE : ECALL_MMODE;
    else if (instr.op == EBREAK)
        code = BREAKPOINT;
    else if (mis[1])
        code = LOAD_ADDR_MISALIGNED;
    else if (mis[0])
        code = STORE_ADDR_MISALIGNED;
    else
        code = NO_EXC;
    raise = (code != NO_EXC) && (instr.op != NOP);
endfunction

`endif

// File: sim/tb_execute.sv
// Execute stage testbench with LFSR stimulus, model checks
// and error counting
`timescale 1ns/1ps
`default_nettype none

module tb_execute import isa_pkg::*, exec_pkg::*; ();

    localparam bit COMPRESSED = 1'b0;
    localparam int NUM_INSTR  = 2000;
    localparam int MAX_CYCLES = 3 * NUM_INSTR;

    logic            clk;
    logic            reset_n;
    logic            stall_i;
    exec_in_t        exec_in_i;
    logic [XLEN-1:0] csr_data_read_i;
    mem_req_t        mem_req_o;
    wb_t             wb_o;
    csr_req_t        csr_req_o;
    logic            jump_o;
    logic [XLEN-1:0] jump_target_o;
    logic            raise_exception_o;
    exc_code_e       exception_code_o;

    mem_req_t    exp_mem;    // Registered outputs after the next edge
    wb_t         exp_wb;
    logic [31:0] lfsr_state = 32'd87593;
    int          checks;
    int          comb_errors;
    int          reg_errors;
    int          cycles;

    execute_stage #(
        .COMPRESSED (COMPRESSED)
    ) UUT (
        .clk               (clk),
        .reset_n           (reset_n),
        .stall_i           (stall_i),
        .exec_in_i         (exec_in_i),
        .csr_data_read_i   (csr_data_read_i),
        .mem_req_o         (mem_req_o),
        .wb_o              (wb_o),
        .csr_req_o         (csr_req_o),
        .jump_o            (jump_o),
        .jump_target_o     (jump_target_o),
        .raise_exception_o (raise_exception_o),
        .exception_code_o  (exception_code_o)
    );

    `include "exec_model.svh"

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic compare_value(input string name, input logic [71:0] got,
                                 input logic [71:0] expected, input logic registered);
        checks++;
        assert (got === expected) else begin
            $display("error %s expected %h got %h", name, expected, got);
            if (registered)
                reg_errors++;
            else
                comb_errors++;
        end
    endtask

    task automatic drive_instruction();
        exec_in_t   instr;
        logic [1:0] priv_sel;
        instr.op             = op_e'(6'(random_bits(6) % 37));
        instr.rs1_data       = random_bits(32);
        instr.rs2_data       = random_bits(32);
        instr.second_operand = random_bits(1) ? instr.rs2_data : random_bits(32);
        if (random_bits(2) == 0)
            instr.second_operand = instr.rs1_data;    // Equal operands for BEQ/BNE
        instr.rd = 5'(random_bits(5));
        if (random_bits(3) == 0)
            instr.rd = '0;
        instr.rs1 = 5'(random_bits(5));
        if (random_bits(3) == 0)
            instr.rs1 = '0;
        instr.jump_imm_target = random_bits(32);
        instr.pc_next         = random_bits(32);
        instr.csr_address     = 12'(random_bits(12));
        priv_sel = 2'(random_bits(2));
        instr.privilege = (priv_sel == 2'd0) ? USER : (priv_sel == 2'd1) ? SUPERVISOR : MACHINE;
        instr.illegal_inst = (random_bits(4) == 0);
        exec_in_i       = instr;
        csr_data_read_i = random_bits(32);
        stall_i         = (random_bits(3) == 0);    // One cycle in eight
    endtask

    task automatic verify_registers();
        compare_value("mem_req_o", 72'(mem_req_o), 72'(exp_mem), 1'b1);
        compare_value("wb_o", 72'(wb_o), 72'(exp_wb), 1'b1);
    endtask

    task automatic verify_same_cycle();
        logic            taken;
        logic [XLEN-1:0] target;
        logic            raise;
        logic            csr_bad;
        exc_code_e       code;
        csr_req_t        csr_exp;
        branch_outcome(exec_in_i, taken, target);
        trap_outcome(exec_in_i, raise, code);
        csr_exp = csr_request(exec_in_i, csr_bad);
        compare_value("jump_o", 72'(jump_o), 72'(taken), 1'b0);
        if (exec_in_i.op inside {JAL, JALR, BEQ, BNE, BLT, BLTU, BGE, BGEU})
            compare_value("jump_target_o", 72'(jump_target_o), 72'(target), 1'b0);
        compare_value("csr_req_o", 72'(csr_req_o), 72'(csr_exp), 1'b0);
        compare_value("raise_exception_o", 72'(raise_exception_o), 72'(raise), 1'b0);
        compare_value("exception_code_o", 72'(exception_code_o), 72'(code), 1'b0);
        if (!stall_i) begin    // Registers load on the next edge
            exp_mem             = memory_request(exec_in_i);
            exp_wb.write_enable = write_allowed(exec_in_i, raise);
            exp_wb.rd           = exec_in_i.rd;
            exp_wb.result       = select_result(exec_in_i, csr_data_read_i);
            exp_wb.op           = exec_in_i.op;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock, timeout and main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the instruction sequence did not finish", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int n;
        reset_n         = 1'b0;
        stall_i         = 1'b0;
        exec_in_i       = '0;
        csr_data_read_i = '0;
        exp_mem         = '0;    // Reset state
        exp_wb          = '{write_enable: 1'b0, rd: '0, result: '0, op: NOP};
        checks          = 0;
        comb_errors     = 0;
        reg_errors      = 0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        for (n = 0; n < NUM_INSTR; n++) begin
            verify_registers();
            drive_instruction();
            #1;
            verify_same_cycle();
            @(posedge clk);
            #1;
        end
        verify_registers();
        $display("Checks %0d, combinational errors %0d, registered errors %0d",
                 checks, comb_errors, reg_errors);
        if (comb_errors + reg_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
